/* audio_calib_stim.txt */
// word = cmd_a_b in hex. cmd 1 idle a cycles, 2 calibrate, 3 raw sample a with corrected b,
// 4 expect offset a, 5 expect peak a, 6 expect calib_busy a, 0 end of stimulus.
1_0004_0000
6_0000_0000
// window 1, no offset yet.
3_0064_0064
3_FF38_FF38
3_012C_012C
3_8000_8000
3_0032_0032
3_0000_0000
3_04D2_04D2
3_FFFB_FFFB
5_7FFF_0000
1_0002_0000
// calibration 1, sum -8003 gives floor mean -1001.
2_0000_0000
6_0001_0000
3_FC18_FC18
3_FC17_FC17
3_FC19_FC19
3_FC16_FC16
2_0000_0000 // ignored while busy
6_0001_0000
3_FC18_FC18
3_FC18_FC18
3_FC17_FC17
3_FC18_FC18
4_FC17_0000
6_0000_0000
5_03EA_0000
1_0002_0000
6_0000_0000
// window 3, offset -1001 with positive saturation.
3_0000_03E9
3_7D00_7FFF
3_7C16_7FFF
3_8000_83E9
3_0064_044D
3_FC17_0000
3_F830_FC19
3_01F4_05DD
5_7FFF_0000
// calibration 2, sum 16006 gives floor mean 2000.
2_0000_0000
6_0001_0000
3_07D0_0BB9
3_07D0_0BB9
3_07D1_0BBA
3_07D3_0BBC
3_07CF_0BB8
3_07D0_0BB9
3_07D2_0BBB
3_07D1_0BBA
4_07D0_0000
6_0000_0000
5_0BBC_0000
1_0002_0000
// window 5, offset 2000 with negative saturation.
3_8300_8000
3_87D0_8000
3_07D0_0000
3_0000_F830
3_7FFF_782F
3_09C4_01F4
3_03E8_FC18
3_8000_8000
5_7FFF_0000
// window 6, small values after the maximum restarts.
3_07DA_000A
3_07C6_FFF6
3_08FC_012C
3_06A4_FED4
1_0001_0000
3_06A3_FED3
3_07D0_0000
3_0834_0064
3_0802_0032
5_012D_0000
1_0004_0000
6_0000_0000
0_0000_0000

/* src.f */
audio_pkg.sv
meas_pkg.sv
dc_offset_estimator.sv
dc_offset_remover.sv
peak_meter.sv
audio_calib_top.sv
audio_calib_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run the testbench and judge the run from sim.log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module audio_calib_tb -o audio_calib_sim \
    && ./obj_dir/audio_calib_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

[ -f sim.log ] || { echo "no simulation log was written"; exit 1; }
cat sim.log

grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "simulation FAILED"; exit 1; }
echo "simulation PASSED"
exit 0

/* audio_calib_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_calib_tb;

    localparam int STIM_DEPTH = 128;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_LATENCY = 2; // last raw sample of a window to its level report.

    // command codes in the top nibble of each stimulus word.
    localparam logic [3:0] CMD_END = 4'h0;
    localparam logic [3:0] CMD_IDLE = 4'h1;
    localparam logic [3:0] CMD_CALIB = 4'h2;
    localparam logic [3:0] CMD_SAMPLE = 4'h3;
    localparam logic [3:0] CMD_OFFSET = 4'h4;
    localparam logic [3:0] CMD_PEAK = 4'h5;
    localparam logic [3:0] CMD_BUSY = 4'h6;

    logic audio_clk;
    logic rst_in;
    audio_pkg::audio_beat_t raw_in;
    logic calib_start;
    audio_pkg::audio_beat_t corr_out;
    audio_pkg::offset_report_t offset_out;
    audio_pkg::level_report_t level_out;
    logic calib_busy;

    logic [35:0] stim_mem [0:STIM_DEPTH-1];

    audio_pkg::sample_t corr_expected [$];
    int corr_due [$];
    audio_pkg::offset_report_t offset_expected [$];
    int offset_due [$];
    audio_pkg::level_report_t level_expected [$];
    int level_due [$];

    int cycle_cnt = 0;
    int cycle_limit = 0;
    int due_cycle;
    audio_pkg::sample_t exp_sample;

    audio_calib_top dut0 (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .raw_in(raw_in),
        .calib_start(calib_start),
        .corr_out(corr_out),
        .offset_out(offset_out),
        .level_out(level_out),
        .calib_busy(calib_busy)
    );

    initial begin
        audio_clk = 1'b0;
        forever #20 audio_clk = ~audio_clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_sample(input string name, input audio_pkg::sample_t expected,
                                  input audio_pkg::sample_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic verify_offset(input audio_pkg::offset_report_t expected,
                                 input audio_pkg::offset_report_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: offset_out expected %0b/%0d, actual %0b/%0d", $time,
                     expected.strobe, expected.offset, actual.strobe, actual.offset);
            abort_run();
        end
    endtask

    task automatic verify_level(input audio_pkg::level_report_t expected,
                                input audio_pkg::level_report_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: level_out expected %0b/%0d, actual %0b/%0d", $time,
                     expected.strobe, expected.peak, actual.strobe, actual.peak);
            abort_run();
        end
    endtask

    task automatic compare_busy(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: calib_busy expected %0b, actual %0b", $time,
                     expected, actual);
            abort_run();
        end
    endtask

    // cycles that the stimulus drives, used to size the timeout.
    function automatic int count_stim_cycles();
        int total;
        int idx;
        logic [35:0] word;
        total = 0;
        idx = 0;
        word = stim_mem[0];
        while (idx < STIM_DEPTH && !$isunknown(word) && word[35:32] != CMD_END) begin
            if (word[35:32] == CMD_IDLE) begin
                total = total + int'(word[31:16]);
            end else if (word[35:32] == CMD_CALIB || word[35:32] == CMD_SAMPLE) begin
                total = total + 1;
            end
            idx = idx + 1;
            if (idx < STIM_DEPTH) begin
                word = stim_mem[idx];
            end
        end
        return total;
    endfunction

    // outputs are read on the rising edge before the DUT updates them.
    always @(posedge audio_clk) begin
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
        if (!rst_in && corr_out.strobe) begin
            if (corr_expected.size() == 0) begin
                $display("unexpected corrected sample %0d at %0t ns", corr_out.data, $time);
                abort_run();
            end else begin
                due_cycle = corr_due.pop_front();
                exp_sample = corr_expected.pop_front();
                if (due_cycle != cycle_cnt) begin
                    $display("corrected sample came in cycle %0d instead of cycle %0d",
                             cycle_cnt, due_cycle);
                    abort_run();
                end else begin
                    compare_sample("corr_out.data", exp_sample, corr_out.data);
                end
            end
        end
        if (!rst_in && offset_out.strobe) begin
            if (offset_expected.size() == 0) begin
                $display("unexpected offset report %0d at %0t ns", offset_out.offset, $time);
                abort_run();
            end else begin
                due_cycle = offset_due.pop_front();
                if (due_cycle != cycle_cnt) begin
                    $display("offset report came in cycle %0d instead of cycle %0d",
                             cycle_cnt, due_cycle);
                    abort_run();
                end else begin
                    verify_offset(offset_expected.pop_front(), offset_out);
                end
            end
        end
        if (!rst_in && level_out.strobe) begin
            if (level_expected.size() == 0) begin
                $display("unexpected peak report %0d at %0t ns", level_out.peak, $time);
                abort_run();
            end else begin
                due_cycle = level_due.pop_front();
                if (due_cycle != cycle_cnt) begin
                    $display("peak report came in cycle %0d instead of cycle %0d",
                             cycle_cnt, due_cycle);
                    abort_run();
                end else begin
                    verify_level(level_expected.pop_front(), level_out);
                end
            end
        end
        cycle_cnt = cycle_cnt + 1;
    end

    initial begin
        int idx;
        int sample_total;
        int drain;
        int last_raw_cycle;
        bit running;
        logic [35:0] word;
        logic [3:0] cmd;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        audio_pkg::offset_report_t exp_offset;
        audio_pkg::level_report_t exp_level;

        rst_in = 1'b1;
        calib_start = 1'b0;
        raw_in = '0;
        $readmemh("audio_calib_stim.txt", stim_mem);
        cycle_limit = (count_stim_cycles() + RESET_CYCLES) * 2 + 100;

        repeat (RESET_CYCLES) @(negedge audio_clk);
        rst_in = 1'b0;

        idx = 0;
        sample_total = 0;
        last_raw_cycle = 0;
        running = 1'b1;
        while (running) begin
            word = stim_mem[idx];
            cmd = word[35:32];
            arg_a = word[31:16];
            arg_b = word[15:0];
            idx = idx + 1;
            case (cmd)
                CMD_END: begin
                    running = 1'b0;
                end
                CMD_IDLE: begin
                    repeat (arg_a) @(negedge audio_clk);
                end
                CMD_CALIB: begin
                    calib_start = 1'b1;
                    @(negedge audio_clk);
                    calib_start = 1'b0;
                end
                CMD_SAMPLE: begin
                    raw_in.strobe = 1'b1;
                    raw_in.data = arg_a;
                    last_raw_cycle = cycle_cnt; // the DUT takes the sample at the next edge.
                    corr_expected.push_back(arg_b);
                    corr_due.push_back(last_raw_cycle + 1);
                    sample_total = sample_total + 1;
                    @(negedge audio_clk);
                    raw_in = '0;
                end
                CMD_OFFSET: begin
                    exp_offset.strobe = 1'b1;
                    exp_offset.offset = arg_a;
                    offset_expected.push_back(exp_offset);
                    offset_due.push_back(last_raw_cycle + 1);
                end
                CMD_PEAK: begin
                    if (sample_total % meas_pkg::PEAK_WINDOW != 0) begin
                        $display("stimulus word %0d expects a peak inside a window", idx - 1);
                        abort_run();
                    end else begin
                        exp_level.strobe = 1'b1;
                        exp_level.peak = arg_a;
                        level_expected.push_back(exp_level);
                        level_due.push_back(last_raw_cycle + MAX_LATENCY);
                    end
                end
                CMD_BUSY: begin
                    compare_busy(arg_a[0], calib_busy);
                end
                default: begin
                    $display("stimulus word %0d holds no valid command", idx - 1);
                    abort_run();
                end
            endcase
        end

        drain = 0;
        while (corr_expected.size() + offset_expected.size() + level_expected.size() != 0
               && drain <= MAX_LATENCY) begin
            @(negedge audio_clk);
            drain = drain + 1;
        end
        if (corr_expected.size() + offset_expected.size() + level_expected.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("missing strobes: %0d corrected, %0d offset, %0d peak",
                     corr_expected.size(), offset_expected.size(), level_expected.size());
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* audio_calib_top.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_calib_top (
    input wire logic audio_clk,
    input wire logic rst_in,
    input audio_pkg::audio_beat_t raw_in,
    input wire logic calib_start,
    output audio_pkg::audio_beat_t corr_out,
    output audio_pkg::offset_report_t offset_out,
    output audio_pkg::level_report_t level_out,
    output logic calib_busy
);

    // raw samples feed both the estimator and the remover.
    dc_offset_estimator estimator0 (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .raw_in(raw_in),
        .calib_start(calib_start),
        .offset_out(offset_out),
        .calib_busy(calib_busy)
    );

    // the offset report doubles as the remover's load strobe.
    dc_offset_remover remover0 (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .raw_in(raw_in),
        .offset_in(offset_out),
        .corr_out(corr_out)
    );

    peak_meter meter0 (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .corr_in(corr_out),
        .level_out(level_out)
    );

endmodule

`default_nettype wire

/* peak_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module peak_meter (
    input wire logic audio_clk,
    input wire logic rst_in,
    input audio_pkg::audio_beat_t corr_in,
    output audio_pkg::level_report_t level_out
);

    localparam logic [meas_pkg::PEAK_CNT_WIDTH-1:0] LAST_IN_WINDOW =
        meas_pkg::PEAK_CNT_WIDTH'(meas_pkg::PEAK_WINDOW - 1);

    audio_pkg::peak_t mag;
    audio_pkg::peak_t max_q;
    audio_pkg::peak_t max_next;
    logic [meas_pkg::PEAK_CNT_WIDTH-1:0] win_cnt;

    // the most negative sample has no positive twin, so it is capped.
    always_comb begin
        if (corr_in.data == audio_pkg::SAMPLE_MIN) begin
            mag = audio_pkg::peak_t'(audio_pkg::SAMPLE_MAX);
        end else if (corr_in.data < 0) begin
            mag = audio_pkg::peak_t'(-corr_in.data);
        end else begin
            mag = audio_pkg::peak_t'(corr_in.data);
        end
    end

    assign max_next = (mag > max_q) ? mag : max_q;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            max_q <= '0;
            win_cnt <= '0;
            level_out.strobe <= 1'b0;
            level_out.peak <= '0;
        end else begin
            level_out.strobe <= 1'b0;
            if (corr_in.strobe) begin
                if (win_cnt == LAST_IN_WINDOW) begin
                    level_out.strobe <= 1'b1;
                    level_out.peak <= max_next; // includes the closing sample.
                    max_q <= '0;
                    win_cnt <= '0;
                end else begin
                    max_q <= max_next;
                    win_cnt <= win_cnt + 1'b1;
                end
            end
        end
    end

    a_report_after_sample: assert property (@(posedge audio_clk) disable iff (rst_in)
        level_out.strobe |-> $past(corr_in.strobe));

endmodule

`default_nettype wire

/* dc_offset_remover.sv */
`timescale 1ns/1ps
`default_nettype none

module dc_offset_remover (
    input wire logic audio_clk,
    input wire logic rst_in,
    input audio_pkg::audio_beat_t raw_in,
    input audio_pkg::offset_report_t offset_in,
    output audio_pkg::audio_beat_t corr_out
);

    localparam int DIFF_WIDTH = audio_pkg::SAMPLE_WIDTH + 1;

    audio_pkg::sample_t offset_q;
    logic signed [DIFF_WIDTH-1:0] diff;
    audio_pkg::sample_t diff_sat;

    // the new offset takes effect on the next raw strobe after the report.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            offset_q <= '0;
        end else if (offset_in.strobe) begin
            offset_q <= offset_in.offset;
        end
    end

    assign diff = DIFF_WIDTH'(raw_in.data) - DIFF_WIDTH'(offset_q);

    // overflow shows as a mismatch between the two top bits.
    always_comb begin
        if (diff[DIFF_WIDTH-1] != diff[DIFF_WIDTH-2]) begin
            if (diff[DIFF_WIDTH-1]) begin
                diff_sat = audio_pkg::SAMPLE_MIN;
            end else begin
                diff_sat = audio_pkg::SAMPLE_MAX;
            end
        end else begin
            diff_sat = audio_pkg::sample_t'(diff);
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            corr_out.strobe <= 1'b0;
            corr_out.data <= '0;
        end else begin
            corr_out.strobe <= raw_in.strobe;
            if (raw_in.strobe) begin
                corr_out.data <= diff_sat; // holds between samples.
            end
        end
    end

    a_strobe_follows_raw: assert property (@(posedge audio_clk) disable iff (rst_in)
        corr_out.strobe |-> $past(raw_in.strobe));

endmodule

`default_nettype wire

/* dc_offset_estimator.sv */
`timescale 1ns/1ps
`default_nettype none

module dc_offset_estimator (
    input wire logic audio_clk,
    input wire logic rst_in,
    input audio_pkg::audio_beat_t raw_in,
    input wire logic calib_start,
    output audio_pkg::offset_report_t offset_out,
    output logic calib_busy
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ACCUM = 2'd1,
        ST_REPORT = 2'd2
    } est_state_t;

    localparam logic [meas_pkg::CALIB_CNT_WIDTH-1:0] LAST_SAMPLE =
        meas_pkg::CALIB_CNT_WIDTH'(meas_pkg::CALIB_COUNT - 1);

    est_state_t state;
    logic signed [meas_pkg::ACC_WIDTH-1:0] acc;
    logic [meas_pkg::CALIB_CNT_WIDTH-1:0] sample_cnt;
    logic signed [meas_pkg::ACC_WIDTH-1:0] mean;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= ST_IDLE;
            acc <= '0;
            sample_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (calib_start) begin
                        acc <= '0;
                        sample_cnt <= '0;
                        state <= ST_ACCUM;
                    end
                end
                ST_ACCUM: begin
                    if (raw_in.strobe) begin
                        acc <= acc + meas_pkg::ACC_WIDTH'(raw_in.data); // sign extends.
                        sample_cnt <= sample_cnt + 1'b1;
                        if (sample_cnt == LAST_SAMPLE) begin
                            state <= ST_REPORT;
                        end
                    end
                end
                ST_REPORT: begin
                    state <= ST_IDLE; // acc keeps the sum so the offset value holds.
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // arithmetic shift gives the floor of the mean.
    assign mean = acc >>> meas_pkg::CALIB_LOG2;

    assign offset_out.strobe = (state == ST_REPORT);
    assign offset_out.offset = audio_pkg::sample_t'(mean);
    assign calib_busy = (state == ST_ACCUM);

    a_single_report: assert property (@(posedge audio_clk) disable iff (rst_in)
        offset_out.strobe |=> !offset_out.strobe);

    a_idle_on_report: assert property (@(posedge audio_clk) disable iff (rst_in)
        offset_out.strobe |-> !calib_busy);

endmodule

`default_nettype wire

/* meas_pkg.sv */
`default_nettype none

package meas_pkg;

    // calibration averages 2**CALIB_LOG2 samples.
    localparam int CALIB_LOG2 = 3;
    localparam int CALIB_COUNT = 1 << CALIB_LOG2;

    // one spare bit so the counter width never collapses to zero.
    localparam int CALIB_CNT_WIDTH = CALIB_LOG2 + 1;

    // sample width plus growth of the sum plus a sign guard bit.
    localparam int ACC_WIDTH = audio_pkg::SAMPLE_WIDTH + CALIB_LOG2 + 1;

    // samples per metering window.
    localparam int PEAK_WINDOW = 8;
    localparam int PEAK_CNT_WIDTH = $clog2(PEAK_WINDOW + 1);

endpackage

`default_nettype wire

/* audio_pkg.sv */
`default_nettype none

package audio_pkg;

    localparam int SAMPLE_WIDTH = 16;
    localparam int PEAK_WIDTH = 16;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [PEAK_WIDTH-1:0] peak_t;

    // saturation limits of a signed 16-bit sample.
    localparam sample_t SAMPLE_MAX = 16'sh7FFF;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    typedef struct packed {
        logic strobe; // one cycle per sample.
        sample_t data;
    } audio_beat_t;

    typedef struct packed {
        logic strobe; // high for the report cycle only.
        sample_t offset;
    } offset_report_t;

    typedef struct packed {
        logic strobe;
        peak_t peak; // capped magnitude, never above SAMPLE_MAX.
    } level_report_t;

endpackage

`default_nettype wire
